//--- hdl/limb_fma.sv
`timescale 1ns/1ns
`include "mp_settings.svh"

module limb_fma (
   input  logic                clk,
   input  logic                rst,
   input  logic                a_shift,
   input  logic                clear,
   input  logic                step,
   input  mp_types_pkg::limb_t a_in,
   input  mp_types_pkg::limb_t b_bcast,
   input  mp_types_pkg::limb_t r_next,
   output mp_types_pkg::limb_t a_out,
   output mp_types_pkg::limb_t r_out,
   output mp_types_pkg::limb_t h_out,
   output mp_types_pkg::limb_t lo_out
);
   import mp_types_pkg::*;

   limb_t      a_reg;
   limb_t      r_reg;
   limb_t      h_reg;
   limb_pair_u t;

   // a*b + r + h stays below 2^(2w), no overflow
   always_comb begin
      t.full = dlimb_t'(a_reg) * dlimb_t'(b_bcast) + dlimb_t'(r_reg) + dlimb_t'(h_reg);
   end

   assign a_out  = a_reg;
   assign r_out  = r_reg;
   assign h_out  = h_reg;
   assign lo_out = t.half.lo;

   // A limb, takes the upper neighbour's limb on each load
   always_ff @(posedge clk) begin
      if (a_shift) begin
         a_reg <= a_in;
      end
   end

   // running limb moves down one lane per step, carry stays put
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         r_reg <= '0;
         h_reg <= '0;
      end else if (clear) begin
         r_reg <= '0;
         h_reg <= '0;
      end else if (step) begin
         r_reg <= r_next;
         h_reg <= t.half.hi;
      end
   end

   clear_step_excl: assert property (
      @(posedge clk) disable iff (!rst) !(clear && step)
   ) else $error("lane saw clear and step in the same cycle");

endmodule

//--- hdl/mp_ctrl_pkg.sv
package mp_ctrl_pkg;

   // sequencer phases of one multiplication
   // idle   waits for start, operand loading allowed
   // clear  zeroes running limbs and carries in every lane
   // step   one B limb per cycle, one low product limb retired
   // drain  collector ripples the lane residue into the upper limbs
   typedef enum logic [1:0] {
      PH_IDLE  = 2'd0,
      PH_CLEAR = 2'd1,
      PH_STEP  = 2'd2,
      PH_DRAIN = 2'd3
   } seq_phase_e;

endpackage

//--- hdl/mp_mul_top.sv
`timescale 1ns/1ns
`include "mp_settings.svh"

module mp_mul_top (
   input  logic                clk,
   input  logic                rst,
   input  logic                a_wr,
   input  mp_types_pkg::limb_t a_limb,
   input  logic                b_wr,
   input  mp_types_pkg::limb_t b_limb,
   input  logic                start,
   output logic                busy,
   output logic                p_valid,
   output mp_types_pkg::limb_t p_limb,
   output logic                p_last
);
   import mp_types_pkg::*;

   logic                            a_shift;
   logic                            clear;
   logic                            step;
   logic                            drain;
   limb_t                           b_bcast;

   // a_link[i] is lane i's A limb, the top entry is the host port
   limb_t                           a_link [`MP_LIMBS+1];
   // lo_link[i] is lane i's low result, the top entry is zero fill
   limb_t                           lo_link [`MP_LIMBS+1];
   logic [`MP_LIMBS*`MP_LIMB_W-1:0] r_vec;
   logic [`MP_LIMBS*`MP_LIMB_W-1:0] h_vec;

   assign a_link[`MP_LIMBS]  = a_limb;
   assign lo_link[`MP_LIMBS] = '0;

   operand_sequencer u_seq (
      .clk     (clk),
      .rst     (rst),
      .a_wr    (a_wr),
      .b_wr    (b_wr),
      .start   (start),
      .p_last  (p_last),
      .b_limb  (b_limb),
      .busy    (busy),
      .a_shift (a_shift),
      .clear   (clear),
      .step    (step),
      .drain   (drain),
      .b_bcast (b_bcast)
   );

   for (genvar i = 0; i < `MP_LIMBS; i++) begin : g_lane
      limb_fma u_lane (
         .clk     (clk),
         .rst     (rst),
         .a_shift (a_shift),
         .clear   (clear),
         .step    (step),
         .a_in    (a_link[i+1]),
         .b_bcast (b_bcast),
         .r_next  (lo_link[i+1]),
         .a_out   (a_link[i]),
         .r_out   (r_vec[i*`MP_LIMB_W +: `MP_LIMB_W]),
         .h_out   (h_vec[i*`MP_LIMB_W +: `MP_LIMB_W]),
         .lo_out  (lo_link[i])
      );
   end

   // lane 0 low half is the retired product limb
   result_collector u_coll (
      .clk     (clk),
      .rst     (rst),
      .step    (step),
      .drain   (drain),
      .emit    (lo_link[0]),
      .r_vec   (r_vec),
      .h_vec   (h_vec),
      .p_valid (p_valid),
      .p_limb  (p_limb),
      .p_last  (p_last)
   );

endmodule

//--- hdl/mp_settings.svh
`ifndef MP_SETTINGS_SVH
`define MP_SETTINGS_SVH

// width of one operand limb in bits
`define MP_LIMB_W 32

// limbs per operand, product has twice as many
// 2, 4 or 8 limbs give a working array
`define MP_LIMBS 4

`endif

//--- hdl/mp_types_pkg.sv
`include "mp_settings.svh"

package mp_types_pkg;

   // one operand limb
   typedef logic [`MP_LIMB_W-1:0] limb_t;

   // double limb, wide enough for a limb product plus two addends
   typedef logic [2*`MP_LIMB_W-1:0] dlimb_t;

   // hi first so it sits on the upper bits of the word
   typedef struct packed {
      limb_t hi;
      limb_t lo;
   } limb_pair_s;

   // lane result or collector sum
   // written whole, read back as carry and output limb
   typedef union packed {
      dlimb_t     full;
      limb_pair_s half;
   } limb_pair_u;

endpackage

//--- hdl/operand_sequencer.sv
`timescale 1ns/1ns
`include "mp_settings.svh"

module operand_sequencer (
   input  logic                clk,
   input  logic                rst,
   input  logic                a_wr,
   input  logic                b_wr,
   input  logic                start,
   input  logic                p_last,
   input  mp_types_pkg::limb_t b_limb,
   output logic                busy,
   output logic                a_shift,
   output logic                clear,
   output logic                step,
   output logic                drain,
   output mp_types_pkg::limb_t b_bcast
);
   import mp_types_pkg::*;
   import mp_ctrl_pkg::*;

   seq_phase_e                 phase;
   logic [$clog2(`MP_LIMBS):0] cnt;
   logic                       cnt_last;
   logic                       b_shift;
   limb_t                      b_buf [`MP_LIMBS];

   assign busy = (phase != PH_IDLE);

   // host writes only land while idle
   assign a_shift = a_wr & ~busy;
   assign b_shift = b_wr & ~busy;

   assign clear = (phase == PH_CLEAR);
   assign step  = (phase == PH_STEP);
   // drain runs for MP_LIMBS cycles, then waits on the collector
   assign drain = (phase == PH_DRAIN) && (cnt != `MP_LIMBS);

   assign cnt_last = (cnt == `MP_LIMBS - 1);

   // broadcast limb j during step j
   assign b_bcast = step ? b_buf[cnt[$clog2(`MP_LIMBS)-1:0]] : '0;

   // B buffer shifts down like the lane chain
   always_ff @(posedge clk) begin
      if (b_shift) begin
         for (int i = 0; i < `MP_LIMBS - 1; i++) begin
            b_buf[i] <= b_buf[i + 1];
         end
         b_buf[`MP_LIMBS - 1] <= b_limb;
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         phase <= PH_IDLE;
         cnt   <= '0;
      end else begin
         case (phase)
            PH_IDLE: begin
               if (start) begin
                  phase <= PH_CLEAR;
                  cnt   <= '0;
               end
            end
            PH_CLEAR: begin
               phase <= PH_STEP;
               cnt   <= '0;
            end
            PH_STEP: begin
               if (cnt_last) begin
                  phase <= PH_DRAIN;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            PH_DRAIN: begin
               if (drain) begin
                  cnt <= cnt + 1'b1;
               end else if (p_last) begin
                  // final limb is out so busy drops on this edge
                  phase <= PH_IDLE;
                  cnt   <= '0;
               end
            end
            default: begin
               phase <= PH_IDLE;
               cnt   <= '0;
            end
         endcase
      end
   end

   // collector flags its top limb one cycle after the last drain
   last_after_drain: assert property (
      @(posedge clk) disable iff (!rst) (phase == PH_DRAIN && !drain) |-> p_last
   ) else $error("collector did not flag the last limb right after drain");

   // p_last anywhere else would go unseen by the phase logic
   last_only_at_end: assert property (
      @(posedge clk) disable iff (!rst) p_last |-> (phase == PH_DRAIN && !drain)
   ) else $error("p_last arrived outside the end of a run");

endmodule

//--- hdl/result_collector.sv
`timescale 1ns/1ns
`include "mp_settings.svh"

module result_collector (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              step,
   input  logic                              drain,
   input  mp_types_pkg::limb_t               emit,
   input  logic [`MP_LIMBS*`MP_LIMB_W-1:0]   r_vec,
   input  logic [`MP_LIMBS*`MP_LIMB_W-1:0]   h_vec,
   output logic                              p_valid,
   output mp_types_pkg::limb_t               p_limb,
   output logic                              p_last
);
   import mp_types_pkg::*;

   logic [$clog2(`MP_LIMBS)-1:0] k;
   logic                         k_last;
   limb_t                        carry;
   limb_t                        r_k;
   limb_t                        h_k;
   limb_pair_u                   sum;

   // lane k residue for upper limb k
   assign r_k = r_vec[k*`MP_LIMB_W +: `MP_LIMB_W];
   assign h_k = h_vec[k*`MP_LIMB_W +: `MP_LIMB_W];

   assign k_last = (k == `MP_LIMBS - 1);

   // carry out of this limb is never more than one
   always_comb begin
      sum.full = dlimb_t'(r_k) + dlimb_t'(h_k) + dlimb_t'(carry);
   end

   // low product limbs during step and upper ones during drain
   always_ff @(posedge clk) begin
      if (step) begin
         p_limb <= emit;
      end else if (drain) begin
         p_limb <= sum.half.lo;
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         p_valid <= 1'b0;
         p_last  <= 1'b0;
         k       <= '0;
         carry   <= '0;
      end else begin
         p_valid <= step | drain;
         p_last  <= drain & k_last;
         if (step) begin
            // carry pass of a new run starts from lane 0
            k     <= '0;
            carry <= '0;
         end else if (drain) begin
            k     <= k + 1'b1;
            carry <= sum.half.hi;
         end
      end
   end

   // the full product fits 2*MP_LIMBS limbs, so nothing is left over
   final_carry_zero: assert property (
      @(posedge clk) disable iff (!rst) p_last |-> carry == '0
   ) else $error("carry left over after the top product limb");

endmodule

//--- mp_mul_top.f
+incdir+hdl
hdl/mp_types_pkg.sv
hdl/mp_ctrl_pkg.sv
hdl/operand_sequencer.sv
hdl/limb_fma.sv
hdl/result_collector.sv
hdl/mp_mul_top.sv
tb/tb_mp_mul.sv

//--- tb/tb_mp_mul.sv
`timescale 1ns/1ns
`include "mp_settings.svh"

module tb_mp_mul;
   import mp_types_pkg::*;
   import mp_ctrl_pkg::*;

   localparam int LW        = `MP_LIMB_W;
   localparam int NL        = `MP_LIMBS;
   localparam int OPW       = LW * NL;
   localparam int RUN_LIMIT = 4 * NL + 16;

   logic  clk;
   logic  rst;
   logic  a_wr;
   logic  b_wr;
   logic  start;
   logic  busy;
   logic  p_valid;
   logic  p_last;
   limb_t a_limb;
   limb_t b_limb;
   limb_t p_limb;

   // operands as last loaded while idle
   logic [OPW-1:0]   a_val;
   logic [OPW-1:0]   b_val;
   logic [OPW-1:0]   ones;
   logic [OPW-1:0]   one;
   logic [2*OPW-1:0] exp_prod;

   int    out_idx;
   bit    started;
   string test_name;
   int    mismatches;
   int    protocol_errs;
   int    timeouts;

   mp_mul_top dut (
      .clk     (clk),
      .rst     (rst),
      .a_wr    (a_wr),
      .a_limb  (a_limb),
      .b_wr    (b_wr),
      .b_limb  (b_limb),
      .start   (start),
      .busy    (busy),
      .p_valid (p_valid),
      .p_limb  (p_limb),
      .p_last  (p_last)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // index of the next product limb, restarts on an accepted start
   always @(posedge clk) begin
      if (start && !busy) begin
         out_idx <= 0;
      end else if (p_valid) begin
         out_idx <= out_idx + 1;
      end
   end

   product_limb_ok: assert property (
      @(posedge clk) disable iff (!rst) p_valid |-> p_limb == exp_prod[out_idx*LW +: LW]
   ) else begin
      mismatches++;
      $display("MISMATCH %s limb %0d expected %h actual %h", test_name, $sampled(out_idx),
               exp_prod[$sampled(out_idx)*LW +: LW], $sampled(p_limb));
   end

   // two quiet cycles, then one unbroken burst of 2*NL limbs
   valid_burst_ok: assert property (
      @(posedge clk) disable iff (!rst)
      (start && !busy) |-> !p_valid ##1 !p_valid ##1 !p_valid ##1 p_valid [*2*NL] ##1 !p_valid
   ) else begin
      protocol_errs++;
      $display("p_valid did not form a burst of %0d limbs three cycles after start in %s",
               2 * NL, test_name);
   end

   last_flag_ok: assert property (
      @(posedge clk) disable iff (!rst)
      (start && !busy) |-> !p_last [*2*NL+2] ##1 p_last ##1 !p_last
   ) else begin
      protocol_errs++;
      $display("p_last was not on the final product limb in %s", test_name);
   end

   busy_span_ok: assert property (
      @(posedge clk) disable iff (!rst)
      (start && !busy) |-> ##1 busy [*2*NL+2] ##1 !busy
   ) else begin
      protocol_errs++;
      $display("busy did not stay high until the edge after p_last in %s", test_name);
   end

   quiet_before_start: assert property (
      @(posedge clk) disable iff (!rst) !started |-> !busy && !p_valid && !p_last
   ) else begin
      protocol_errs++;
      $display("an output was active after reset before any start pulse");
   end

   function automatic logic [OPW-1:0] rand_operand();
      logic [OPW-1:0] v;
      for (int k = 0; k < NL; k++) begin
         v[k*LW +: LW] = $urandom;
      end
      return v;
   endfunction

   // lowest limb first, A and B side by side
   task automatic load_operands(input logic [OPW-1:0] a, input logic [OPW-1:0] b);
      a_val = a;
      b_val = b;
      for (int k = 0; k < NL; k++) begin
         @(posedge clk);
         a_wr   <= 1'b1;
         a_limb <= a[k*LW +: LW];
         b_wr   <= 1'b1;
         b_limb <= b[k*LW +: LW];
      end
      @(posedge clk);
      a_wr <= 1'b0;
      b_wr <= 1'b0;
   endtask

   task automatic begin_run(input string name);
      test_name = name;
      @(posedge clk);
      start    <= 1'b1;
      started  <= 1'b1;
      // full width product, context width is 2*OPW
      exp_prod <= a_val * b_val;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic wait_idle(input int limit);
      int         n;
      seq_phase_e ph;
      n = 0;
      @(negedge clk);
      while (busy && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (busy) begin
         timeouts++;
         ph = dut.u_seq.phase;
         $display("timeout in %s, still busy after %0d cycles in phase %s",
                  test_name, limit, ph.name());
      end
   endtask

   task automatic run_product(input string name);
      begin_run(name);
      wait_idle(RUN_LIMIT);
   endtask

   // a full operand of junk and a second start, all while busy
   task automatic run_with_stray_writes(input string name);
      begin_run(name);
      for (int k = 0; k < NL; k++) begin
         @(posedge clk);
         a_wr   <= 1'b1;
         a_limb <= limb_t'($urandom);
         b_wr   <= 1'b1;
         b_limb <= limb_t'($urandom);
         start  <= (k == 1);
      end
      @(posedge clk);
      a_wr  <= 1'b0;
      b_wr  <= 1'b0;
      start <= 1'b0;
      wait_idle(RUN_LIMIT);
   endtask

   initial begin
      void'($urandom(68));
      rst       = 1'b0;
      a_wr      = 1'b0;
      b_wr      = 1'b0;
      start     = 1'b0;
      a_limb    = '0;
      b_limb    = '0;
      started   = 1'b0;
      exp_prod  = '0;
      test_name = "reset";
      ones      = '1;
      one       = 1;
      repeat (5) @(posedge clk);
      rst <= 1'b1;
      // several idle edges for the reset state check
      repeat (8) @(posedge clk);

      load_operands(ones, ones);
      run_product("all_ones");
      load_operands('0, rand_operand());
      run_product("zero_times_random");
      load_operands(one, rand_operand());
      run_product("one_times_random");

      for (int n = 0; n < 20; n++) begin
         load_operands(rand_operand(), rand_operand());
         run_product($sformatf("random_%0d", n));
      end

      load_operands(rand_operand(), rand_operand());
      run_with_stray_writes("busy_writes");
      // same operands again, stray writes must not have shifted in
      run_product("rerun_after_busy_writes");
      load_operands(rand_operand(), rand_operand());
      run_product("reload_after_busy_writes");

      repeat (4) @(posedge clk);
      $display("errors: %0d mismatch, %0d protocol, %0d timeout",
               mismatches, protocol_errs, timeouts);
      if (mismatches == 0 && protocol_errs == 0 && timeouts == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
